/* verilog/glb_defs.svh */
// global buffer sizes and address fields

`ifndef GLB_DEFS_SVH
`define GLB_DEFS_SVH

// tiles in the west to east chain
`define GLB_NUM_TILES 4

// bank word and byte enables
`define GLB_DATA_WIDTH 64
`define GLB_STRB_WIDTH (`GLB_DATA_WIDTH / 8)

// byte address = {tile select, bank word address, byte offset}
`define GLB_BYTE_OFFSET_WIDTH 3
`define GLB_BANK_ADDR_WIDTH 6
`define GLB_TILE_SEL_WIDTH 2
`define GLB_ADDR_WIDTH (`GLB_BYTE_OFFSET_WIDTH + `GLB_BANK_ADDR_WIDTH + `GLB_TILE_SEL_WIDTH)

`endif

/* verilog/glb_pkg.sv */
// global buffer shared types

`include "glb_defs.svh"

package glb_pkg;

    // processor byte address
    typedef logic [`GLB_ADDR_WIDTH-1:0] glb_addr_t;

    // one bank word and its byte strobe
    typedef logic [`GLB_DATA_WIDTH-1:0] glb_data_t;
    typedef logic [`GLB_STRB_WIDTH-1:0] glb_strb_t;

    // word address inside one bank
    typedef logic [`GLB_BANK_ADDR_WIDTH-1:0] bank_addr_t;

    // tile number, same width as the tile-select field
    typedef logic [`GLB_TILE_SEL_WIDTH-1:0] tile_id_t;

endpackage

/* verilog/proc_pkt_if.sv */
// processor packet stage between tiles

interface proc_pkt_if import glb_pkg::*; ();

    // write request
    logic      wr_en;
    glb_strb_t wr_strb;
    glb_addr_t wr_addr;
    glb_data_t wr_data;

    // read request
    logic      rd_en;
    glb_addr_t rd_addr;

    // read response, travels with its request
    glb_data_t rd_data;
    logic      rd_data_valid;

    // west side of a stage drives it
    modport upstream (
        output wr_en, wr_strb, wr_addr, wr_data,
        output rd_en, rd_addr,
        output rd_data, rd_data_valid
    );

    // east side of a stage consumes it
    modport downstream (
        input wr_en, wr_strb, wr_addr, wr_data,
        input rd_en, rd_addr,
        input rd_data, rd_data_valid
    );

endinterface

/* verilog/proc_ingress.sv */
// processor request input register

module proc_ingress import glb_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       wr_en,
    input  glb_strb_t  wr_strb,
    input  glb_addr_t  wr_addr,
    input  glb_data_t  wr_data,
    input  logic       rd_en,
    input  glb_addr_t  rd_addr,
    proc_pkt_if.upstream pkt_out
);

    logic      wr_en_q;
    logic      rd_en_q;
    glb_strb_t wr_strb_q;
    glb_addr_t wr_addr_q;
    glb_data_t wr_data_q;
    glb_addr_t rd_addr_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_en_q <= 1'b0;
            rd_en_q <= 1'b0;
        end else begin
            wr_en_q <= wr_en;
            rd_en_q <= rd_en;
        end
    end

    // payload only moves with its strobe
    always_ff @(posedge clk) begin
        if (wr_en) begin
            wr_strb_q <= wr_strb;
            wr_addr_q <= wr_addr;
            wr_data_q <= wr_data;
        end
        if (rd_en) begin
            rd_addr_q <= rd_addr;
        end
    end

    assign pkt_out.wr_en   = wr_en_q;
    assign pkt_out.wr_strb = wr_strb_q;
    assign pkt_out.wr_addr = wr_addr_q;
    assign pkt_out.wr_data = wr_data_q;
    assign pkt_out.rd_en   = rd_en_q;
    assign pkt_out.rd_addr = rd_addr_q;

    // no response yet at the head of the chain
    assign pkt_out.rd_data       = '0;
    assign pkt_out.rd_data_valid = 1'b0;

    // one packet stage carries either a write or a read
    a_no_wr_rd_overlap: assert property (@(posedge clk) disable iff (reset)
        !(wr_en && rd_en))
        else $error("processor write and read issued in the same cycle");

endmodule

/* verilog/glb_bank.sv */
// tile memory bank with byte strobes

`include "glb_defs.svh"

module glb_bank import glb_pkg::*; (
    input  logic       clk,
    input  logic       wr_en,
    input  glb_strb_t  wr_strb,
    input  bank_addr_t wr_addr,
    input  glb_data_t  wr_data,
    input  logic       rd_en,
    input  bank_addr_t rd_addr,
    output glb_data_t  rd_data
);

    localparam int DEPTH = 2 ** `GLB_BANK_ADDR_WIDTH;

    glb_data_t mem [DEPTH];

    // only strobed bytes change
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < `GLB_STRB_WIDTH; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    // synchronous read, output holds while idle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* verilog/glb_tile.sv */
// global buffer tile, one chain stage

`include "glb_defs.svh"

module glb_tile import glb_pkg::*; #(
    parameter tile_id_t TILE_ID = '0
) (
    input  logic           clk,
    input  logic           reset,
    proc_pkt_if.downstream west,
    proc_pkt_if.upstream   east
);

    // address field positions
    localparam int BANK_LSB = `GLB_BYTE_OFFSET_WIDTH;
    localparam int TILE_LSB = BANK_LSB + `GLB_BANK_ADDR_WIDTH;

    tile_id_t   wr_tile;
    tile_id_t   rd_tile;
    logic       wr_hit;
    logic       rd_hit;
    bank_addr_t bank_wr_addr;
    bank_addr_t bank_rd_addr;
    glb_data_t  bank_rd_data;

    // registered stage toward the east
    logic      wr_en_q;
    glb_strb_t wr_strb_q;
    glb_addr_t wr_addr_q;
    glb_data_t wr_data_q;
    logic      rd_en_q;
    glb_addr_t rd_addr_q;
    glb_data_t rd_data_q;
    logic      rd_data_valid_q;
    logic      rd_served;

    // tile decode
    assign wr_tile = west.wr_addr[TILE_LSB +: `GLB_TILE_SEL_WIDTH];
    assign rd_tile = west.rd_addr[TILE_LSB +: `GLB_TILE_SEL_WIDTH];
    assign wr_hit  = west.wr_en && (wr_tile == TILE_ID);
    assign rd_hit  = west.rd_en && (rd_tile == TILE_ID);

    assign bank_wr_addr = west.wr_addr[BANK_LSB +: `GLB_BANK_ADDR_WIDTH];
    assign bank_rd_addr = west.rd_addr[BANK_LSB +: `GLB_BANK_ADDR_WIDTH];

    glb_bank u_bank (
        .clk     (clk),
        .wr_en   (wr_hit),
        .wr_strb (west.wr_strb),
        .wr_addr (bank_wr_addr),
        .wr_data (west.wr_data),
        .rd_en   (rd_hit),
        .rd_addr (bank_rd_addr),
        .rd_data (bank_rd_data)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_en_q         <= 1'b0;
            rd_en_q         <= 1'b0;
            rd_data_valid_q <= 1'b0;
            rd_served       <= 1'b0;
        end else begin
            wr_en_q         <= west.wr_en;
            rd_en_q         <= west.rd_en;
            rd_data_valid_q <= west.rd_data_valid;
            rd_served       <= rd_hit;
        end
    end

    always_ff @(posedge clk) begin
        wr_strb_q <= west.wr_strb;
        wr_addr_q <= west.wr_addr;
        wr_data_q <= west.wr_data;
        rd_addr_q <= west.rd_addr;
        rd_data_q <= west.rd_data;
    end

    assign east.wr_en   = wr_en_q;
    assign east.wr_strb = wr_strb_q;
    assign east.wr_addr = wr_addr_q;
    assign east.wr_data = wr_data_q;
    assign east.rd_en   = rd_en_q;
    assign east.rd_addr = rd_addr_q;

    // bank word arrives together with the registered stage
    assign east.rd_data       = rd_served ? bank_rd_data : rd_data_q;
    assign east.rd_data_valid = rd_served | rd_data_valid_q;

    // a read is answered by exactly one tile on its way east
    a_no_resp_collision: assert property (@(posedge clk) disable iff (reset)
        rd_hit |-> !west.rd_data_valid)
        else $error("tile %0d served a read that already had a response", TILE_ID);

endmodule

/* verilog/proc_egress.sv */
// read response output register

module proc_egress import glb_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    proc_pkt_if.downstream  pkt_in,
    output glb_data_t       rd_data,
    output logic            rd_data_valid
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_data_valid <= 1'b0;
        end else begin
            rd_data_valid <= pkt_in.rd_data_valid;
        end
    end

    // keep the last returned word between responses
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_data <= '0;
        end else if (pkt_in.rd_data_valid) begin
            rd_data <= pkt_in.rd_data;
        end
    end

    // every response leaving the chain belongs to a read request
    a_resp_has_request: assert property (@(posedge clk) disable iff (reset)
        rd_data_valid |-> $past(pkt_in.rd_en))
        else $error("read response without a matching read request");

endmodule

/* verilog/global_buffer.sv */
// global buffer, processor access path

`include "glb_defs.svh"

module global_buffer import glb_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    // processor write
    input  logic      proc_wr_en,
    input  glb_strb_t proc_wr_strb,
    input  glb_addr_t proc_wr_addr,
    input  glb_data_t proc_wr_data,

    // processor read
    input  logic      proc_rd_en,
    input  glb_addr_t proc_rd_addr,
    output glb_data_t proc_rd_data,
    output logic      proc_rd_data_valid
);

    // stage 0 from ingress, stage k+1 from tile k
    proc_pkt_if stage [`GLB_NUM_TILES+1] ();

    proc_ingress u_ingress (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (proc_wr_en),
        .wr_strb (proc_wr_strb),
        .wr_addr (proc_wr_addr),
        .wr_data (proc_wr_data),
        .rd_en   (proc_rd_en),
        .rd_addr (proc_rd_addr),
        .pkt_out (stage[0])
    );

    genvar i;
    generate
        for (i = 0; i < `GLB_NUM_TILES; i++) begin : g_tile
            glb_tile #(
                .TILE_ID (tile_id_t'(i))
            ) u_tile (
                .clk   (clk),
                .reset (reset),
                .west  (stage[i]),
                .east  (stage[i+1])
            );
        end
    endgenerate

    // responses leave from the east end of the chain
    proc_egress u_egress (
        .clk           (clk),
        .reset         (reset),
        .pkt_in        (stage[`GLB_NUM_TILES]),
        .rd_data       (proc_rd_data),
        .rd_data_valid (proc_rd_data_valid)
    );

endmodule

/* dv/tb_global_buffer.sv */
// global buffer testbench

`include "glb_defs.svh"

module tb_global_buffer import glb_pkg::*; ();

    // valid follows the edge that drove the read by tiles + 2 edges
    localparam int RESP_LATENCY  = `GLB_NUM_TILES + 2;
    localparam int DRAIN_TIMEOUT = 100;
    localparam string VECTOR_FILE = "dv/glb_vectors.txt";

    logic      clk;
    logic      reset;
    logic      proc_wr_en;
    glb_strb_t proc_wr_strb;
    glb_addr_t proc_wr_addr;
    glb_data_t proc_wr_data;
    logic      proc_rd_en;
    glb_addr_t proc_rd_addr;
    glb_data_t proc_rd_data;
    logic      proc_rd_data_valid;

    // expected words and the cycle each one is due
    glb_data_t exp_q[$];
    int        due_q[$];
    int        cycle = 0;

    global_buffer DUT (
        .clk                (clk),
        .reset              (reset),
        .proc_wr_en         (proc_wr_en),
        .proc_wr_strb       (proc_wr_strb),
        .proc_wr_addr       (proc_wr_addr),
        .proc_wr_data       (proc_wr_data),
        .proc_rd_en         (proc_rd_en),
        .proc_rd_addr       (proc_rd_addr),
        .proc_rd_data       (proc_rd_data),
        .proc_rd_data_valid (proc_rd_data_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            proc_wr_en = 1'b0;
            proc_rd_en = 1'b0;
        end
    endtask

    task automatic issue_write(input glb_addr_t addr, input glb_strb_t strb,
                               input glb_data_t data);
        @(posedge clk);
        #1;
        proc_wr_en   = 1'b1;
        proc_rd_en   = 1'b0;
        proc_wr_addr = addr;
        proc_wr_strb = strb;
        proc_wr_data = data;
    endtask

    task automatic issue_read(input glb_addr_t addr, input glb_data_t expected);
        @(posedge clk);
        #1;
        proc_wr_en   = 1'b0;
        proc_rd_en   = 1'b1;
        proc_rd_addr = addr;
        exp_q.push_back(expected);
        due_q.push_back(cycle + RESP_LATENCY);
    endtask

    // response checker, sampled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (due_q.size() > 0 && due_q[0] == cycle) begin
                if (!proc_rd_data_valid) begin
                    $display("read response missing at cycle %0d", cycle);
                    abort_run();
                end else begin
                    check("proc_rd_data", proc_rd_data, exp_q[0]);
                    void'(exp_q.pop_front());
                    void'(due_q.pop_front());
                end
            end else begin
                check("proc_rd_data_valid", proc_rd_data_valid, 1'b0);
            end
        end
    end

    initial begin
        int        fd;
        int        n;
        int        waited;
        string     line;
        logic [7:0] op;
        glb_addr_t addr;
        glb_strb_t strb;
        glb_data_t data;

        reset        = 1'b1;
        proc_wr_en   = 1'b0;
        proc_wr_strb = '0;
        proc_wr_addr = '0;
        proc_wr_data = '0;
        proc_rd_en   = 1'b0;
        proc_rd_addr = '0;
        void'($urandom(32'h3ae6));

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("could not open the vector file %s", VECTOR_FILE);
            abort_run();
        end

        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line[0] != "#" && line[0] != "\n" && line[0] != "\r") begin
                n = $sscanf(line, "%c %h %h %h", op, addr, strb, data);
                if (n != 4) begin
                    $display("malformed vector line: %s", line);
                    abort_run();
                end
                // upper case ops get a random idle gap, lower case go next cycle
                if (op == "W" || op == "R") begin
                    idle_cycles($urandom % 4);
                end
                if (op == "W" || op == "w") begin
                    issue_write(addr, strb, data);
                end else if (op == "R" || op == "r") begin
                    issue_read(addr, data);
                end else begin
                    $display("unknown operation in vector line: %s", line);
                    abort_run();
                end
            end
        end
        $fclose(fd);
        idle_cycles(1);

        // let the outstanding reads drain
        waited = 0;
        while (exp_q.size() > 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end

        // quiet tail, no stray responses
        idle_cycles(RESP_LATENCY + 2);

        if (exp_q.size() != 0) begin
            $display("timed out waiting for %0d read responses", exp_q.size());
            abort_run();
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

/* filelist.f */
+incdir+verilog
verilog/glb_pkg.sv
verilog/proc_pkt_if.sv
verilog/proc_ingress.sv
verilog/glb_bank.sv
verilog/glb_tile.sv
verilog/proc_egress.sv
verilog/global_buffer.sv
dv/tb_global_buffer.sv

/* dv/glb_vectors.txt */
# op addr strb data, all hex; W writes, R reads and data is the expected word
# upper case op waits a random idle gap first, lower case op issues on the next cycle
# full writes, one per tile, then read back
W 008 ff 1111111111111111
W 210 ff 2222222222222222
W 418 ff 3333333333333333
W 620 ff 4444444444444444
R 008 00 1111111111111111
R 210 00 2222222222222222
R 418 00 3333333333333333
R 620 00 4444444444444444
# partial strobes merge with the old word
W 0f8 ff 0123456789abcdef
W 0f8 0f aaaaaaaaaaaaaaaa
R 0f8 00 01234567aaaaaaaa
W 500 ff fedcba9876543210
W 500 a5 5555555555555555
R 500 00 55dc559876553255
W 7f8 ff cafef00ddeadbeef
W 7f8 80 0000000000000000
W 7f8 01 ffffffffffffffff
R 7f8 00 00fef00ddeadbeff
W 7f8 00 1234567812345678
r 7f8 00 00fef00ddeadbeff
# same bank word in every tile
W 028 ff a0a0a0a0a0a0a0a0
W 228 ff b1b1b1b1b1b1b1b1
W 428 ff c2c2c2c2c2c2c2c2
W 628 ff d3d3d3d3d3d3d3d3
R 428 00 c2c2c2c2c2c2c2c2
R 028 00 a0a0a0a0a0a0a0a0
R 628 00 d3d3d3d3d3d3d3d3
R 228 00 b1b1b1b1b1b1b1b1
R 42f 00 c2c2c2c2c2c2c2c2
# back to back reads, several in flight
R 008 00 1111111111111111
r 210 00 2222222222222222
r 418 00 3333333333333333
r 620 00 4444444444444444
r 0f8 00 01234567aaaaaaaa
r 500 00 55dc559876553255
r 7f8 00 00fef00ddeadbeff
r 028 00 a0a0a0a0a0a0a0a0
r 228 00 b1b1b1b1b1b1b1b1
r 628 00 d3d3d3d3d3d3d3d3
# read right after a write to the same address
W 130 ff 0f0f0f0f0f0f0f0f
r 130 00 0f0f0f0f0f0f0f0f
W 130 3c 7777777777777777
r 130 00 0f0f777777770f0f
W 6a8 ff 1234abcd5678ef01
r 6a8 00 1234abcd5678ef01
W 3c0 ff 8888888888888888
r 3c0 00 8888888888888888
w 3c0 ff 9999999999999999
r 3c0 00 9999999999999999
w 3c0 f0 0000000000000000
r 3c0 00 0000000099999999
# mixed traffic across tiles
W 5f0 ff 0badc0de0badc0de
R 008 00 1111111111111111
r 5f0 00 0badc0de0badc0de
W 208 ff 7e7e7e7e7e7e7e7e
R 208 00 7e7e7e7e7e7e7e7e
R 130 00 0f0f777777770f0f
